// ==== filelist.f ====
+incdir+source
source/fetch_pkg.sv
source/fetch_stage.sv
source/fetch_buffer.sv
source/inst_splitter.sv
source/fetch_top.sv
tests/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module fetch_tb -f filelist.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vfetch_tb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi

echo "simulation did not report a pass"
exit 1

// ==== tests/fetch_tb.sv ====
// fetch front end testbench
// clock and reset, Wishbone instruction memory model, LFSR,
// stimulus rows applied in a loop, scoreboard and compare tasks
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_tb;

	localparam int AW = `FETCH_ADDR_W;
	localparam int IW = `FETCH_INST_W;
	localparam int NUM_ROWS = 6;
	localparam int ROW_TIMEOUT = 4000;		// cycles per row

	logic						clock;
	logic						reset;
	logic						wb_cyc;
	logic						wb_stb;
	logic						wb_we;
	logic [AW-1:0]				wb_adr;
	logic [7:0]					wb_sel;
	logic [`FETCH_LINE_W-1:0]	wb_dat_in;
	logic						wb_ack;
	logic						redirect_valid;
	fetch_pkg::thread_t			redirect_thread;
	logic [AW-1:0]				redirect_pc;
	logic						two_threads;
	logic						inst_valid;
	logic [IW-1:0]				inst_data;
	logic [AW-1:0]				inst_pc;
	fetch_pkg::thread_t			inst_thread;
	logic						inst_ready;

	fetch_top DUT (.*);

	// one stimulus row, halt locations are instruction addresses
	typedef struct packed {
		logic				two;
		logic [AW-1:0]		halt0;
		logic [AW-1:0]		halt1;
		logic				redir_en;
		int					redir_after;	// outputs of that thread before it fires
		fetch_pkg::thread_t	redir_thread;
		logic [AW-1:0]		redir_pc;
		logic				rand_ready;
		int					exp0;			// instructions expected from thread 0
		int					exp1;
	} row_t;

	row_t					rows [0:NUM_ROWS-1];
	string					names [0:NUM_ROWS-1];
	row_t					cur;
	string					cur_name;
	logic [31:0]			lfsr;
	int						count [0:1];		// delivered per thread
	int						expect_n [0:1];
	logic [AW-1:0]			next_pc [0:1];		// scoreboard, next expected address
	logic [IW-1:0]			last_data [0:1];
	logic					active;
	logic					fired;
	logic					mem_busy;
	logic [1:0]				mem_wait;
	logic					first_seen;
	logic					stb_wait;
	logic [AW-1:0]			prev_adr;
	logic					hold_prev;
	logic [IW+AW:0]			prev_out;			// data, pc, thread
	int						errors;

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	////////////////////////////////////////
	// LFSR and memory contents
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);	// galois, right shift
	endfunction

	task automatic take_bits(input int n, output logic [3:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[2:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);				// one step per bit
		end
	endtask

	// slot k of line a is {a[15:0], k, 15'h0} unless it is a halt location
	function automatic logic [IW-1:0] mem_inst(input logic [AW-1:0] addr);
		if (addr == cur.halt0 || addr == cur.halt1) begin
			return `FETCH_HALT_WORD;
		end
		return {addr[15:3], 3'b000, addr[2], 15'h0000};
	endfunction

	////////////////////////////////////////
	// failure reporting and compares
	task automatic abort_run();
		errors = errors + 1;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", cur_name, what);
		abort_run();
	endtask

	task automatic check_inst(input string name, input logic [IW-1:0] exp_data,
			input logic [IW-1:0] act_data, input logic [AW-1:0] exp_pc,
			input logic [AW-1:0] act_pc);
		if (act_pc !== exp_pc) begin
			$display("[ERROR] %s: pc expected %h, actual %h", name, exp_pc, act_pc);
			abort_run();
		end
		if (act_data !== exp_data) begin
			$display("[ERROR] %s: data expected %h, actual %h", name, exp_data, act_data);
			abort_run();
		end
	endtask

	task automatic check_thread(input string name, input fetch_pkg::thread_t exp_t,
			input fetch_pkg::thread_t act_t);
		if (act_t !== exp_t) begin
			$display("[ERROR] %s: thread expected %0d, actual %0d", name, exp_t, act_t);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [AW-1:0] exp_a,
			input logic [AW-1:0] act_a);
		if (act_a !== exp_a) begin
			$display("[ERROR] %s: wb_adr expected %h, actual %h", name, exp_a, act_a);
			abort_run();
		end
	endtask

	// read only master, full line select, cyc and stb move together
	task automatic check_bus_ctrl(input string name, input logic exp_stb,
			input logic act_stb, input logic act_we, input logic [7:0] act_sel);
		if (act_stb !== exp_stb) begin
			$display("[ERROR] %s: wb_stb expected %b, actual %b", name, exp_stb, act_stb);
			abort_run();
		end
		if (exp_stb && act_we !== 1'b0) begin
			$display("[ERROR] %s: wb_we expected 0, actual %b", name, act_we);
			abort_run();
		end
		if (exp_stb && act_sel !== 8'hff) begin
			$display("[ERROR] %s: wb_sel expected ff, actual %h", name, act_sel);
			abort_run();
		end
	endtask

	////////////////////////////////////////
	// one cycle, inputs change 2 ns after the edge
	task automatic cycle_step();
		logic [3:0] bits;
		@(posedge clock);
		#2;
		if (reset || wb_ack) begin				// ack lasts one cycle
			wb_ack = 1'b0;
			mem_busy = 1'b0;
		end
		else if (wb_cyc && wb_stb) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				take_bits(2, bits);
				mem_wait = bits[1:0];			// 0 to 3 cycles
			end
			else begin
				mem_wait = mem_wait - 2'd1;
			end
			if (mem_wait == 2'd0) begin
				wb_ack = 1'b1;
				wb_dat_in = {mem_inst(wb_adr + AW'(4)), mem_inst(wb_adr)};
			end
		end
		redirect_valid = 1'b0;
		if (!reset && cur.redir_en && !fired && count[cur.redir_thread] == cur.redir_after) begin
			redirect_valid = 1'b1;
			redirect_thread = cur.redir_thread;
			redirect_pc = cur.redir_pc;
			inst_ready = 1'b0;					// no transfer at the redirect edge
			fired = 1'b1;
		end
		else if (cur.rand_ready) begin
			take_bits(1, bits);
			inst_ready = bits[0];
		end
		else begin
			inst_ready = 1'b1;
		end
	endtask

	////////////////////////////////////////
	// monitor, sampled mid cycle
	always @(negedge clock) begin
		fetch_pkg::thread_t t;
		if (active) begin
			check_bus_ctrl(cur_name, wb_cyc, wb_stb, wb_we, wb_sel);
			if (stb_wait && (!wb_stb || wb_adr !== prev_adr)) begin
				report_failure("wb_stb or wb_adr changed before wb_ack");
			end
			if (wb_stb && !first_seen) begin
				check_addr(cur_name, `FETCH_T0_START, wb_adr);	// thread 0 goes first
				first_seen = 1'b1;
			end
			stb_wait = wb_stb & ~wb_ack;
			prev_adr = wb_adr;
			if (hold_prev && (!inst_valid || {inst_data, inst_pc, inst_thread} !== prev_out)) begin
				report_failure("instruction output changed while inst_ready was low");
			end
			if (inst_valid && inst_ready) begin
				t = inst_thread;
				// thread 1 lives at and above its start address
				check_thread(cur_name,
					cur.two ? fetch_pkg::thread_t'(inst_pc >= `FETCH_T1_START) : 1'b0, t);
				if (count[t] >= expect_n[t]) begin
					report_failure($sformatf("thread %0d sent more instructions than expected", t));
				end
				check_inst(cur_name, mem_inst(next_pc[t]), inst_data, next_pc[t], inst_pc);
				last_data[t] = inst_data;
				next_pc[t] = next_pc[t] + AW'(4);
				count[t] = count[t] + 1;
			end
			if (redirect_valid) begin
				next_pc[redirect_thread] = redirect_pc;		// target itself comes first
			end
			hold_prev = inst_valid & ~inst_ready & ~redirect_valid;
			prev_out = {inst_data, inst_pc, inst_thread};
		end
	end

	////////////////////////////////////////
	// rows
	task automatic set_row(input int i, input string name, input int two, input int h0,
			input int h1, input int re, input int ra, input int rt, input int rp,
			input int rr, input int e0, input int e1);
		names[i] = name;
		rows[i] = row_t'{1'(two), h0, h1, 1'(re), ra, 1'(rt), rp, 1'(rr), e0, e1};
	endtask

	task automatic apply_row(input int r);
		int waited;
		cur = rows[r];
		cur_name = names[r];
		active = 1'b0;
		reset = 1'b1;
		two_threads = cur.two;
		fired = 1'b0;
		first_seen = 1'b0;
		stb_wait = 1'b0;
		hold_prev = 1'b0;
		count[0] = 0;
		count[1] = 0;
		expect_n[0] = cur.exp0;
		expect_n[1] = cur.exp1;
		next_pc[0] = `FETCH_T0_START;
		next_pc[1] = `FETCH_T1_START;
		repeat (10) cycle_step();
		reset = 1'b0;
		if (wb_cyc || wb_stb || inst_valid) begin
			report_failure("Wishbone or instruction output active right after reset");
		end
		active = 1'b1;
		waited = 0;
		while (count[0] < expect_n[0] || count[1] < expect_n[1]) begin
			if (waited >= ROW_TIMEOUT) begin
				report_failure("timed out waiting for the expected instructions");
			end
			cycle_step();
			waited = waited + 1;
		end
		repeat (20) begin							// both threads halted, all quiet
			cycle_step();
			if (wb_cyc || inst_valid) begin
				report_failure("Wishbone cycle or instruction after the last halt");
			end
		end
		// the last one of each thread is its halt word
		for (int t = 0; t < 2; t++) begin
			if (expect_n[t] > 0) begin
				check_inst(cur_name, `FETCH_HALT_WORD, last_data[t],
					t == 0 ? cur.halt0 : cur.halt1, next_pc[t] - AW'(4));
			end
		end
	endtask

	initial begin
		errors = 0;
		lfsr = 32'hbe5b_0934;
		active = 1'b0;
		reset = 1'b1;
		wb_ack = 1'b0;
		wb_dat_in = '0;
		redirect_valid = 1'b0;
		redirect_thread = 1'b0;
		redirect_pc = '0;
		two_threads = 1'b0;
		inst_ready = 1'b0;
		mem_busy = 1'b0;
		mem_wait = 2'd0;
		// name, two, halt t0, halt t1, redirect en/after/thread/target, rand ready, t0, t1
		set_row(0, "single_basic", 0, 'h0018, 'h1014, 0, 0, 0, 'h0000, 0, 7, 0);
		set_row(1, "single_rand", 0, 'h0020, 'h1014, 0, 0, 0, 'h0000, 1, 9, 0);
		set_row(2, "dual_basic", 1, 'h001c, 'h1010, 0, 0, 0, 'h0000, 0, 8, 5);
		set_row(3, "dual_rand", 1, 'h002c, 'h1024, 0, 0, 0, 'h0000, 1, 12, 10);
		set_row(4, "redirect_halted", 0, 'h0018, 'h1014, 1, 7, 0, 'h000c, 1, 11, 0);
		set_row(5, "redirect_mid", 1, 'h0014, 'h1030, 1, 3, 1, 'h102c, 1, 6, 5);
		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_row(r);
		end
		if (errors == 0) begin
			$display("PASS: all tests");
			$finish;
		end
		else begin
			$display("FAIL: see errors above");
			$fatal(1, "errors found");
		end
	end

endmodule

// ==== source/fetch_top.sv ====
// fetch_top: fetch stage, bundle FIFO and instruction splitter
// wired to the Wishbone memory port and the back end
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_top (
	input  logic						clock,
	input  logic						reset,
	// Wishbone classic master
	output logic						wb_cyc,
	output logic						wb_stb,
	output logic						wb_we,
	output logic [`FETCH_ADDR_W-1:0]	wb_adr,
	output logic [7:0]					wb_sel,
	input  logic [`FETCH_LINE_W-1:0]	wb_dat_in,
	input  logic						wb_ack,
	// back end control
	input  logic						redirect_valid,
	input  fetch_pkg::thread_t			redirect_thread,
	input  logic [`FETCH_ADDR_W-1:0]	redirect_pc,
	input  logic						two_threads,
	// instruction stream
	output logic						inst_valid,
	output logic [`FETCH_INST_W-1:0]	inst_data,
	output logic [`FETCH_ADDR_W-1:0]	inst_pc,
	output fetch_pkg::thread_t			inst_thread,
	input  logic						inst_ready
);

	logic						push_valid;
	fetch_pkg::fetch_bundle_t	push_bundle;
	logic						full;
	logic						empty;
	fetch_pkg::fetch_bundle_t	head_bundle;
	logic						pop;
	logic [1:0]					thread_epoch;	// live epochs, fetch to splitter

	////////////////////////////////////////
	// producer
	fetch_stage u_fetch_stage (
		.clock				(clock),
		.reset				(reset),
		.two_threads		(two_threads),
		.redirect_valid		(redirect_valid),
		.redirect_thread	(redirect_thread),
		.redirect_pc		(redirect_pc),
		.full				(full),
		.wb_dat_in			(wb_dat_in),
		.wb_ack				(wb_ack),
		.wb_cyc				(wb_cyc),
		.wb_stb				(wb_stb),
		.wb_we				(wb_we),
		.wb_adr				(wb_adr),
		.wb_sel				(wb_sel),
		.push_valid			(push_valid),
		.push_bundle		(push_bundle),
		.thread_epoch		(thread_epoch)
	);

	// bundle queue
	fetch_buffer u_fetch_buffer (
		.clock			(clock),
		.reset			(reset),
		.push			(push_valid),
		.push_bundle	(push_bundle),
		.pop			(pop),
		.full			(full),
		.empty			(empty),
		.head_bundle	(head_bundle)
	);

	// consumer
	inst_splitter u_inst_splitter (
		.clock			(clock),
		.reset			(reset),
		.empty			(empty),
		.head_bundle	(head_bundle),
		.thread_epoch	(thread_epoch),
		.pop			(pop),
		.inst_ready		(inst_ready),
		.inst_valid		(inst_valid),
		.inst_data		(inst_data),
		.inst_pc		(inst_pc),
		.inst_thread	(inst_thread)
	);

endmodule

// ==== source/inst_splitter.sv ====
// inst_splitter: takes bundles from the FIFO head and sends one
// instruction per cycle under valid/ready, dropping stale and empty slots
`timescale 1ns/100ps
`include "fetch_settings.svh"

module inst_splitter (
	input  logic						clock,
	input  logic						reset,
	input  logic						empty,
	input  fetch_pkg::fetch_bundle_t	head_bundle,
	input  logic [1:0]					thread_epoch,	// live epochs from fetch
	output logic						pop,
	input  logic						inst_ready,
	output logic						inst_valid,
	output logic [`FETCH_INST_W-1:0]	inst_data,
	output logic [`FETCH_ADDR_W-1:0]	inst_pc,
	output fetch_pkg::thread_t			inst_thread
);

	localparam int AW = `FETCH_ADDR_W;
	localparam int IW = `FETCH_INST_W;

	fetch_pkg::fetch_bundle_t	hold;			// bundle being sent
	logic						held;			// hold has something to send
	logic						slot;			// always points at a valid slot
	logic						held_stale;
	logic						head_stale;
	logic						head_good;
	logic						last_slot;
	logic						fire;
	logic						free;			// register can take a new bundle

	////////////////////////////////////////
	// drop decisions
	assign held_stale = (hold.epoch != thread_epoch[hold.thread]);
	assign head_stale = (head_bundle.epoch != thread_epoch[head_bundle.thread]);
	assign head_good  = ~head_stale & (|head_bundle.slot_valid);

	assign last_slot = slot | ~hold.slot_valid[1];	// nothing left after this one
	assign inst_valid = held & ~held_stale;
	assign fire       = inst_valid & inst_ready;
	assign free       = ~held | held_stale | (fire & last_slot);
	assign pop        = free & ~empty;				// bad heads get popped and lost

	// output view of the current slot
	assign inst_data   = slot ? hold.line[2*IW-1:IW] : hold.line[IW-1:0];
	assign inst_pc     = hold.line_pc + {{(AW-3){1'b0}}, slot, 2'b00};
	assign inst_thread = hold.thread;

	////////////////////////////////////////
	// slot sequencing
	always_ff @(posedge clock) begin
		if (reset) begin
			held <= 1'b0;
			slot <= 1'b0;
		end
		else if (pop) begin
			held <= head_good;
			slot <= ~head_bundle.slot_valid[0];	// start at first valid slot
		end
		else if (free) begin
			held <= 1'b0;						// stale or done, nothing queued
		end
		else if (fire) begin
			slot <= 1'b1;						// slot 0 sent, slot 1 next
		end
	end

	// bundle register
	always_ff @(posedge clock) begin
		if (pop && head_good) begin
			hold <= head_bundle;
		end
	end

endmodule

// ==== source/fetch_buffer.sv ====
// fetch_buffer: circular FIFO of fetch bundles
// push, pop, full and empty, with push and pop allowed together when full
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_buffer (
	input  logic						clock,
	input  logic						reset,
	input  logic						push,
	input  fetch_pkg::fetch_bundle_t	push_bundle,
	input  logic						pop,
	output logic						full,
	output logic						empty,
	output fetch_pkg::fetch_bundle_t	head_bundle
);

	localparam int DEPTH = `FETCH_BUF_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	fetch_pkg::fetch_bundle_t	mem [0:DEPTH-1];	// bundle storage
	logic [PTR_W-1:0]			wr_ptr;
	logic [PTR_W-1:0]			rd_ptr;
	logic [PTR_W:0]				count;				// one extra bit for full
	logic						do_push;
	logic						do_pop;

	assign full  = (count == (PTR_W+1)'(DEPTH));
	assign empty = (count == '0);

	// a push into a full FIFO only goes when the head leaves the same cycle
	assign do_push = push & (~full | pop);
	assign do_pop  = pop & ~empty;

	assign head_bundle = mem[rd_ptr];				// visible the cycle after push

	////////////////////////////////////////
	// pointers and count
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;	// wraps at DEPTH
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;			// none or both
			endcase
		end
	end

	// storage
	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_bundle;
		end
	end

endmodule

// ==== source/fetch_stage.sv ====
// fetch_stage: per-thread pc, done flag and epoch, thread selection,
// Wishbone classic fetch master, halt detection and redirect handling
`timescale 1ns/100ps
`include "fetch_settings.svh"

module fetch_stage (
	input  logic						clock,
	input  logic						reset,
	input  logic						two_threads,	// high enables thread 1
	input  logic						redirect_valid,
	input  fetch_pkg::thread_t			redirect_thread,
	input  logic [`FETCH_ADDR_W-1:0]	redirect_pc,
	input  logic						full,			// bundle FIFO has no room
	input  logic [`FETCH_LINE_W-1:0]	wb_dat_in,
	input  logic						wb_ack,
	output logic						wb_cyc,
	output logic						wb_stb,
	output logic						wb_we,
	output logic [`FETCH_ADDR_W-1:0]	wb_adr,
	output logic [7:0]					wb_sel,
	output logic						push_valid,
	output fetch_pkg::fetch_bundle_t	push_bundle,
	output logic [1:0]					thread_epoch
);

	localparam int AW = `FETCH_ADDR_W;
	localparam int IW = `FETCH_INST_W;

	////////////////////////////////////////
	// per-thread state
	logic [AW-1:0]		pc [0:1];		// next line to fetch
	logic [1:0]			done;			// thread fetched its halt word
	logic [1:0]			epoch;			// flips on every redirect
	logic [1:0]			skip0;			// next line starts at slot 1

	// request bookkeeping
	fetch_pkg::thread_t	last_thread;	// thread of the most recent request
	fetch_pkg::thread_t	req_thread;		// thread of the request in flight
	logic				req_epoch;		// its epoch at issue

	// selection and ack decode
	logic [1:0]			eligible;
	fetch_pkg::thread_t	next_thread;
	logic				issue;
	logic				live_ack;		// ack for a request still on path
	logic [IW-1:0]		inst0;
	logic [IW-1:0]		inst1;
	logic [1:0]			slots;
	logic				halt_hit;

	assign wb_we        = 1'b0;			// read only master
	assign wb_sel       = 8'hff;		// always the full line
	assign thread_epoch = epoch;

	////////////////////////////////////////
	// thread choice
	// alternate, but fall back to the same thread when the other one is out
	assign eligible[0] = ~done[0];
	assign eligible[1] = two_threads & ~done[1];

	always_comb begin
		next_thread = ~last_thread;
		if (!eligible[next_thread]) begin
			next_thread = last_thread;
		end
	end

	// idle, room in the FIFO and someone left to fetch for
	assign issue = ~wb_cyc & ~full & (|eligible);

	////////////////////////////////////////
	// ack decode
	// stale acks (epoch moved while in flight) are thrown away here
	assign live_ack   = wb_cyc & wb_ack & (req_epoch == epoch[req_thread]);
	assign push_valid = live_ack;

	always_comb begin
		inst0    = wb_dat_in[IW-1:0];
		inst1    = wb_dat_in[2*IW-1:IW];
		slots    = {1'b1, ~skip0[req_thread]};	// slot 0 off after odd redirect
		halt_hit = 1'b0;
		if (slots[0] && inst0 == `FETCH_HALT_WORD) begin
			slots[1] = 1'b0;					// nothing after the halt
			halt_hit = 1'b1;
		end
		else if (inst1 == `FETCH_HALT_WORD) begin
			halt_hit = 1'b1;
		end
	end

	always_comb begin
		push_bundle.thread     = req_thread;
		push_bundle.epoch      = req_epoch;
		push_bundle.line_pc    = wb_adr;		// held stable for the whole cycle
		push_bundle.slot_valid = slots;
		push_bundle.line       = wb_dat_in;
	end

	////////////////////////////////////////
	// control state
	always_ff @(posedge clock) begin
		if (reset) begin
			pc[0]       <= `FETCH_T0_START;
			pc[1]       <= `FETCH_T1_START;
			done        <= 2'b00;
			epoch       <= 2'b00;
			skip0       <= 2'b00;
			last_thread <= 1'b1;				// so thread 0 goes first
			wb_cyc      <= 1'b0;
			wb_stb      <= 1'b0;
		end
		else begin
			if (issue) begin
				wb_cyc      <= 1'b1;
				wb_stb      <= 1'b1;
				last_thread <= next_thread;
			end
			else if (wb_cyc && wb_ack) begin	// drop right after the ack
				wb_cyc <= 1'b0;
				wb_stb <= 1'b0;
			end

			if (live_ack) begin
				pc[req_thread]    <= pc[req_thread] + AW'(8);
				skip0[req_thread] <= 1'b0;
				if (halt_hit) begin
					done[req_thread] <= 1'b1;
				end
			end

			// redirect wins over a same-cycle ack of that thread
			if (redirect_valid) begin
				pc[redirect_thread]    <= {redirect_pc[AW-1:3], 3'b000};
				done[redirect_thread]  <= 1'b0;
				epoch[redirect_thread] <= ~epoch[redirect_thread];
				skip0[redirect_thread] <= redirect_pc[2];
			end
		end
	end

	// request address and tags, loaded at issue
	always_ff @(posedge clock) begin
		if (issue) begin
			wb_adr     <= pc[next_thread];
			req_thread <= next_thread;
			req_epoch  <= epoch[next_thread];
		end
	end

endmodule

// ==== source/fetch_pkg.sv ====
// fetch types shared by the front end
// thread id and the fetch bundle that travels through the FIFO
`include "fetch_settings.svh"

package fetch_pkg;

	// thread number, two threads in this core
	typedef logic thread_t;

	////////////////////////////////////////
	// one fetched line plus its bookkeeping
	// slot 0 sits in the low half of line
	typedef struct packed {
		thread_t					thread;		// owning thread
		logic						epoch;		// thread epoch at request time
		logic [`FETCH_ADDR_W-1:0]	line_pc;	// 8-byte aligned line address
		logic [1:0]					slot_valid;	// one bit per instruction
		logic [`FETCH_LINE_W-1:0]	line;		// the two instructions
	} fetch_bundle_t;

	// a bundle with both slots cleared carries nothing for the back end
	// the splitter drops those without an output cycle
	//
	// epoch compare against the live per-thread epoch decides whether
	// a bundle is still on the right path

endpackage

// ==== source/fetch_settings.svh ====
// fetch front end settings
// data widths, thread start addresses, halt encoding, FIFO depth
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

////////////////////////////////////////
// widths
`define FETCH_ADDR_W		32				// byte address
`define FETCH_INST_W		32				// one instruction
`define FETCH_LINE_W		64				// one fetch line, two instructions

////////////////////////////////////////
// thread control
`define FETCH_T0_START		32'h0000_0000	// reset pc of thread 0
`define FETCH_T1_START		32'h0000_1000	// reset pc of thread 1
`define FETCH_HALT_WORD		32'h0000_0555	// ends a thread

////////////////////////////////////////
// bundle FIFO
`define FETCH_BUF_DEPTH		4				// power of two only

`endif
